// File: design/seg_pkg.sv
package seg_pkg;

  // display geometry
  localparam int NUM_DIGITS = 8;              // eight hex digits on the board
  localparam int SCLK_DIV   = 2;              // sys_clk cycles per serial clock half period
  localparam int FRAME_BITS = 16;             // two 595s in a chain, 8 bits each

  // bus side
  typedef logic [31:0] word_t;                // output port word
  typedef logic [3:0]  byte_en_t;             // one enable per byte lane

  // display side
  typedef logic [3:0]  nibble_t;              // one hex digit value
  typedef logic [7:0]  seg_code_t;            // bit0 = a .. bit6 = g, bit7 = dp, active low
  typedef logic [7:0]  digit_sel_t;           // one-hot digit enable, active high
  typedef logic [2:0]  digit_idx_t;           // index of the digit being served

  // one 16-bit frame as shifted out, MSB first
  // seg lands in the far 595, sel in the near one
  typedef struct packed {
    seg_code_t  seg;                          // upper byte, shifted first
    digit_sel_t sel;                          // lower byte
  } frame_t;

  // scanner FSM
  typedef enum logic [1:0] {
    LOAD,                                     // grab code of current digit
    SHIFT_LO,                                 // serial clock low, data settles
    SHIFT_HI,                                 // serial clock high, 595 has sampled
    LATCH                                     // storage strobe pulse
  } scan_state_t;

endpackage

// File: design/pio_out_reg.sv
`timescale 1ns/100ps

module pio_out_reg (
  input  logic             sys_clk,
  input  logic             arst_n,
  input  logic             wr_en,           // single-cycle write strobe
  input  seg_pkg::byte_en_t wr_be,          // byte lanes to replace
  input  seg_pkg::word_t   wr_data,         // new port data
  output seg_pkg::word_t   port_word        // registered port value
);

  seg_pkg::word_t word_q;                   // port register
  seg_pkg::word_t word_nxt;                 // merged value on a write
  seg_pkg::word_t lane_mask;                // byte enables spread to bits

  // expand each enable to a full byte of mask bits
  always_comb begin
    lane_mask = '0;
    for (int b = 0; b < 4; b++) begin
      lane_mask[8*b +: 8] = {8{wr_be[b]}};  // whole lane on or off
    end
  end

  // enabled lanes take bus data, the rest keep old value
  assign word_nxt = (wr_data & lane_mask) | (word_q & ~lane_mask);

  // one cycle write latency, no back-pressure
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      word_q <= '0;                         // display shows all zeros
    end else if (wr_en) begin
      word_q <= word_nxt;                   // be of zero leaves word as is
    end
  end

  assign port_word = word_q;

endmodule

// File: design/hex_seg_enc.sv
`timescale 1ns/100ps

module hex_seg_enc (
  input  seg_pkg::nibble_t   digit,         // hex value 0..F
  output seg_pkg::seg_code_t seg            // common-anode pattern, active low
);

  logic [6:0] pat;                          // segments g..a, low = lit

  // glyph table, lower case b and d so they differ from 8 and 0
  always_comb begin
    case (digit)
      4'h0: pat = 7'h40;
      4'h1: pat = 7'h79;                    // b, c only
      4'h2: pat = 7'h24;
      4'h3: pat = 7'h30;
      4'h4: pat = 7'h19;
      4'h5: pat = 7'h12;
      4'h6: pat = 7'h02;
      4'h7: pat = 7'h78;
      4'h8: pat = 7'h00;                    // all seven lit
      4'h9: pat = 7'h10;
      4'hA: pat = 7'h08;
      4'hB: pat = 7'h03;                    // lower case b
      4'hC: pat = 7'h46;
      4'hD: pat = 7'h21;                    // lower case d
      4'hE: pat = 7'h06;
      4'hF: pat = 7'h0E;
      default: pat = 7'h7F;                 // blank on unknown input
    endcase
  end

  assign seg = {1'b1, pat};                 // dp held dark

endmodule

// File: design/hc595_scan.sv
`timescale 1ns/100ps

module hc595_scan (
  input  logic               sys_clk,
  input  logic               arst_n,
  input  seg_pkg::seg_code_t seg_codes [seg_pkg::NUM_DIGITS], // codes from encoders
  output logic               seg_clk,       // 595 shift clock
  output logic               seg_dat,       // serial data, MSB first
  output logic               seg_str        // 595 storage latch
);

  localparam int DIV_W = $clog2(seg_pkg::SCLK_DIV + 1);   // phase counter width
  localparam int BIT_W = $clog2(seg_pkg::FRAME_BITS);     // bit counter width

  seg_pkg::scan_state_t state;              // current FSM state
  seg_pkg::scan_state_t state_nxt;
  logic [DIV_W-1:0]     div_cnt;            // cycles spent in current phase
  logic [BIT_W-1:0]     bit_cnt;            // bits already clocked out
  seg_pkg::digit_idx_t  digit_idx;          // digit being served
  logic [seg_pkg::FRAME_BITS-1:0] shreg;    // frame being shifted
  seg_pkg::frame_t      frame_new;          // frame built at LOAD
  logic                 div_last;           // end of a half period
  logic                 bit_last;           // 16th bit on the wire

  assign div_last = (div_cnt == DIV_W'(seg_pkg::SCLK_DIV - 1));
  assign bit_last = (bit_cnt == BIT_W'(seg_pkg::FRAME_BITS - 1));

  // segments of the current digit plus its one-hot select
  always_comb begin
    frame_new.seg = seg_codes[digit_idx];
    frame_new.sel = seg_pkg::digit_sel_t'(1) << digit_idx;
  end

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      seg_pkg::LOAD: begin
        state_nxt = seg_pkg::SHIFT_LO;      // LOAD lasts a single cycle
      end
      seg_pkg::SHIFT_LO: begin
        if (div_last) begin
          state_nxt = seg_pkg::SHIFT_HI;    // rising edge, 595 samples
        end
      end
      seg_pkg::SHIFT_HI: begin
        if (div_last) begin
          // after the last high phase go latch, else next bit
          state_nxt = bit_last ? seg_pkg::LATCH : seg_pkg::SHIFT_LO;
        end
      end
      seg_pkg::LATCH: begin
        if (div_last) begin
          state_nxt = seg_pkg::LOAD;        // on to the next digit
        end
      end
      default: begin
        state_nxt = seg_pkg::LOAD;
      end
    endcase
  end

  // FSM, counters and frame register
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= seg_pkg::LOAD;           // idle at digit 0
      div_cnt   <= '0;
      bit_cnt   <= '0;
      digit_idx <= '0;
      shreg     <= '0;
    end else begin
      state <= state_nxt;
      if (state_nxt != state) begin
        div_cnt <= '0;                      // restart phase on every change
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      case (state)
        seg_pkg::LOAD: begin
          shreg   <= frame_new;             // frame frozen from here on
          bit_cnt <= '0;
        end
        seg_pkg::SHIFT_HI: begin
          if (div_last) begin
            shreg   <= shreg << 1;          // next bit to the MSB
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        seg_pkg::LATCH: begin
          if (div_last) begin
            if (digit_idx == seg_pkg::digit_idx_t'(seg_pkg::NUM_DIGITS - 1)) begin
              digit_idx <= '0;              // wrap after last digit
            end else begin
              digit_idx <= digit_idx + 1'b1;
            end
          end
        end
        default: ;
      endcase
    end
  end

  // pins registered off the next state so they line up with it
  always_ff @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      seg_clk <= 1'b0;
      seg_dat <= 1'b0;
      seg_str <= 1'b0;
    end else begin
      seg_clk <= (state_nxt == seg_pkg::SHIFT_HI);
      seg_str <= (state_nxt == seg_pkg::LATCH);   // clock stays low here
      if (state == seg_pkg::LOAD) begin
        seg_dat <= frame_new[seg_pkg::FRAME_BITS-1];  // first bit, clock low
      end else if (state == seg_pkg::SHIFT_HI && div_last && !bit_last) begin
        seg_dat <= shreg[seg_pkg::FRAME_BITS-2];  // changes on falling edge
      end
    end
  end

endmodule

// File: design/seg_display_top.sv
`timescale 1ns/100ps

module seg_display_top (
  input  logic              sys_clk,
  input  logic              arst_n,

  // processor bus write port
  input  logic              wr_en,          // one-cycle strobe
  input  seg_pkg::byte_en_t wr_be,          // byte enables
  input  seg_pkg::word_t    wr_data,        // write data

  // 74HC595 chain pins
  output logic              seg_clk,        // shift clock
  output logic              seg_dat,        // serial data
  output logic              seg_str         // storage strobe
);

  seg_pkg::word_t     port_word;                        // processor output port
  seg_pkg::seg_code_t seg_codes [seg_pkg::NUM_DIGITS];  // one code per digit

  // output port register
  pio_out_reg ins_pio_out_reg (
    .sys_clk   (sys_clk),
    .arst_n    (arst_n),
    .wr_en     (wr_en),
    .wr_be     (wr_be),
    .wr_data   (wr_data),
    .port_word (port_word)
  );

  // digit i shows nibble i, digit 0 is bits 3..0
  for (genvar i = 0; i < seg_pkg::NUM_DIGITS; i++) begin : g_enc
    hex_seg_enc ins_hex_seg_enc (
      .digit (port_word[4*i +: 4]),
      .seg   (seg_codes[i])
    );
  end

  // serializer into the two 595s
  hc595_scan ins_hc595_scan (
    .sys_clk   (sys_clk),
    .arst_n    (arst_n),
    .seg_codes (seg_codes),
    .seg_clk   (seg_clk),
    .seg_dat   (seg_dat),
    .seg_str   (seg_str)
  );

endmodule

// File: bench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic sys_clk,                     // free running, 4 ns period
  output logic arst_n                       // async reset, active low
);

  localparam int HALF_NS    = 2;            // half of the 4 ns period
  localparam int RST_CYCLES = 8;            // edges seen with reset held

  initial begin
    sys_clk = 1'b0;
    forever #HALF_NS sys_clk = ~sys_clk;
  end

  initial begin
    arst_n = 1'b0;                          // held from time zero
    repeat (RST_CYCLES) @(posedge sys_clk);
    arst_n <= 1'b1;                         // released on a rising edge
  end

endmodule

// File: bench/hc595_monitor.sv
`timescale 1ns/100ps

module hc595_monitor (
  input  logic           sys_clk,
  input  logic           arst_n,
  input  logic           seg_clk,           // 595 shift clock from the DUT
  input  logic           seg_dat,           // serial data from the DUT
  input  logic           seg_str,           // 595 storage latch from the DUT
  input  logic           write_seen,        // bench issued a bus write
  input  seg_pkg::word_t model_word,        // expected port word
  output int             error_cnt,
  output int             check_cnt,
  output int             skip_cnt,
  output int             frame_cnt
);

  logic [seg_pkg::FRAME_BITS-1:0] chain;    // both 595 shift stages
  logic clk_q;                              // seg_clk one sys_clk ago
  logic str_q;
  logic dat_q;
  logic dirty;                              // write since previous latch
  int   rise_cnt;                           // seg_clk rises since last latch
  int   exp_idx;                            // digit due in the next frame
  int   errs = 0;
  int   idle_errs = 0;                      // pins not idle in reset
  int   checks = 0;
  int   skips = 0;
  int   frames = 0;

  assign error_cnt = errs + idle_errs;
  assign check_cnt = checks;
  assign skip_cnt  = skips;
  assign frame_cnt = frames;

  // common anode glyphs, dp dark, b and d in lower case
  function automatic seg_pkg::seg_code_t expected_code(input seg_pkg::nibble_t n);
    case (n)
      4'h0: return 8'hC0;
      4'h1: return 8'hF9;
      4'h2: return 8'hA4;
      4'h3: return 8'hB0;
      4'h4: return 8'h99;
      4'h5: return 8'h92;
      4'h6: return 8'h82;
      4'h7: return 8'hF8;
      4'h8: return 8'h80;                   // every segment lit
      4'h9: return 8'h90;
      4'hA: return 8'h88;
      4'hB: return 8'h83;
      4'hC: return 8'hC6;
      4'hD: return 8'hA1;
      4'hE: return 8'h86;
      default: return 8'h8E;                // F
    endcase
  endfunction

  // all three pins stay low while reset is held
  always @(posedge sys_clk) begin
    if (!arst_n && (seg_clk || seg_dat || seg_str)) begin
      $display("Error: pins in reset, expected clk/dat/str 0x0/0x0/0x0, actual 0x%0h/0x%0h/0x%0h",
               seg_clk, seg_dat, seg_str);
      idle_errs <= idle_errs + 1;
    end
  end

  always @(posedge sys_clk or negedge arst_n) begin
    seg_pkg::frame_t     got;               // frame at the 595 outputs
    seg_pkg::digit_sel_t exp_sel;
    seg_pkg::seg_code_t  exp_seg;
    int                  new_errs;          // failures found this cycle
    if (!arst_n) begin
      chain    <= '0;
      clk_q    <= 1'b0;
      str_q    <= 1'b0;
      dat_q    <= 1'b0;
      dirty    <= 1'b0;
      rise_cnt <= 0;
      exp_idx  <= 0;                        // scan starts at digit 0
    end else begin
      new_errs = 0;
      clk_q <= seg_clk;
      str_q <= seg_str;
      dat_q <= seg_dat;
      if (write_seen) begin
        dirty <= 1'b1;
      end
      if (seg_clk && !clk_q) begin
        chain    <= {chain[seg_pkg::FRAME_BITS-2:0], seg_dat};  // 595 samples on rise
        rise_cnt <= rise_cnt + 1;
      end
      if (seg_clk && clk_q && (seg_dat != dat_q)) begin
        $display("seg_dat changed while seg_clk was high");
        new_errs++;
      end
      if (seg_clk && seg_str) begin
        $display("Error: seg_clk during latch, expected 0x0, actual 0x1");
        new_errs++;
      end
      if (seg_str && !str_q) begin
        got     = chain;
        exp_sel = seg_pkg::digit_sel_t'(1) << exp_idx;
        exp_seg = expected_code(model_word[4*exp_idx +: 4]);
        if (rise_cnt != seg_pkg::FRAME_BITS) begin
          $display("Error: seg_clk rises per frame, expected 0x%0h, actual 0x%0h",
                   seg_pkg::FRAME_BITS, rise_cnt);
          new_errs++;
        end
        if (got.sel != exp_sel) begin
          $display("Error: frame sel, expected 0x%02h, actual 0x%02h", exp_sel, got.sel);
          new_errs++;
        end
        if (dirty || write_seen) begin
          skips <= skips + 1;               // code may predate the write
        end else begin
          checks <= checks + 1;
          if (got.seg != exp_seg) begin
            $display("Error: frame seg digit %0d, expected 0x%02h, actual 0x%02h",
                     exp_idx, exp_seg, got.seg);
            new_errs++;
          end
        end
        dirty    <= write_seen;
        rise_cnt <= 0;
        exp_idx  <= (exp_idx + 1) % seg_pkg::NUM_DIGITS;  // wrap after digit 7
        frames   <= frames + 1;
      end
      errs <= errs + new_errs;
    end
  end

endmodule

// File: bench/seg_display_tb.sv
`timescale 1ns/100ps

module seg_display_tb;

  localparam int NUM_WRITES  = 300;
  localparam int FRAME_CYC   = 1 + 2 * seg_pkg::SCLK_DIV * seg_pkg::FRAME_BITS
                               + seg_pkg::SCLK_DIV;           // 67 cycles per digit
  localparam int SCAN_FRAMES = seg_pkg::NUM_DIGITS + 1;       // frame in flight plus full scan
  localparam int MAX_GAP     = 255;                           // from 8 random bits
  localparam int LIMIT       = (NUM_WRITES + 1) * (SCAN_FRAMES * FRAME_CYC + MAX_GAP + 2)
                               + 1000;                        // margin for reset

  logic              sys_clk;
  logic              arst_n;
  logic              wr_en;
  seg_pkg::byte_en_t wr_be;
  seg_pkg::word_t    wr_data;
  logic              seg_clk;
  logic              seg_dat;
  logic              seg_str;
  logic              write_seen;            // pulse to the monitor
  seg_pkg::word_t    model_word;            // expected port register
  int                error_cnt;
  int                check_cnt;
  int                skip_cnt;
  int                frame_cnt;
  int                cycle_cnt = 0;
  logic [15:0]       lfsr = 16'd17;         // fixed seed

  tb_clk_gen clk_gen (.sys_clk(sys_clk), .arst_n(arst_n));

  seg_display_top uut (
    .sys_clk (sys_clk),
    .arst_n  (arst_n),
    .wr_en   (wr_en),
    .wr_be   (wr_be),
    .wr_data (wr_data),
    .seg_clk (seg_clk),
    .seg_dat (seg_dat),
    .seg_str (seg_str)
  );

  hc595_monitor monitor (
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .seg_clk    (seg_clk),
    .seg_dat    (seg_dat),
    .seg_str    (seg_str),
    .write_seen (write_seen),
    .model_word (model_word),
    .error_cnt  (error_cnt),
    .check_cnt  (check_cnt),
    .skip_cnt   (skip_cnt),
    .frame_cnt  (frame_cnt)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit, msb taken first
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[15]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // byte lanes with enable set take new data
  function automatic seg_pkg::word_t merge_bytes(input seg_pkg::word_t old_w,
                                                 input seg_pkg::word_t new_w,
                                                 input seg_pkg::byte_en_t be);
    seg_pkg::word_t w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  task automatic bus_write(input seg_pkg::word_t d, input seg_pkg::byte_en_t be);
    @(posedge sys_clk);
    wr_en      <= 1'b1;                     // single-cycle strobe
    wr_be      <= be;
    wr_data    <= d;
    write_seen <= 1'b1;
    model_word <= merge_bytes(model_word, d, be);
    @(posedge sys_clk);
    wr_en      <= 1'b0;
    write_seen <= 1'b0;
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frame_cnt + n;
    while (frame_cnt < target) begin
      @(posedge sys_clk);
    end
  endtask

  initial begin
    logic [31:0]       r;
    seg_pkg::word_t    d;
    seg_pkg::byte_en_t be;
    wr_en      = 1'b0;
    wr_be      = '0;
    wr_data    = '0;
    write_seen = 1'b0;
    model_word = '0;
    @(posedge arst_n);
    wait_frames(SCAN_FRAMES);               // reset word on every digit
    for (int w = 0; w < NUM_WRITES; w++) begin
      take_bits(32, r);
      d = r;
      take_bits(4, r);
      be = r[3:0];                          // zero enables included
      take_bits(8, r);
      repeat (r[7:0]) @(posedge sys_clk);   // write lands at a random phase
      bus_write(d, be);
      wait_frames(SCAN_FRAMES);
    end
    $display("errors %0d, checks %0d, skipped %0d, frames %0d",
             error_cnt, check_cnt, skip_cnt, frame_cnt);
    if (error_cnt == 0 && check_cnt > 0) begin
      $display("TB PASSED");
    end else begin
      if (check_cnt == 0) begin
        $display("no frame was checked against the model");
      end
      $display("TB FAILED");
    end
    $finish;
  end

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("timeout, run did not end within %0d cycles", LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

endmodule

// File: src.f
design/seg_pkg.sv
design/pio_out_reg.sv
design/hex_seg_enc.sv
design/hc595_scan.sv
design/seg_display_top.sv
bench/tb_clk_gen.sv
bench/hc595_monitor.sv
bench/seg_display_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the display testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module seg_display_tb -f src.f

out=$(./obj_dir/Vseg_display_tb)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "TB PASSED"
